//--- rtl/line_buf_pkg.sv
package line_buf_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    // one feature word
    localparam int pixel_w = 32;
    // feature buffer, 1024 words
    localparam int ifm_aw  = 10;
    // one row buffer, 64 words
    localparam int row_aw  = 6;
    // image width and height
    localparam int dim_w   = 4;
    // channel count
    localparam int chn_w   = 3;

    // --------------------------------------------------
    // vector types
    // --------------------------------------------------
    typedef logic [pixel_w-1:0] pixel_t;
    typedef logic [ifm_aw-1:0]  ifm_addr_t;
    // col * channels + chn inside one row
    typedef logic [row_aw-1:0]  row_addr_t;
    typedef logic [dim_w-1:0]   dim_t;
    typedef logic [chn_w-1:0]   chn_t;

    // role of one row RAM inside the three-row window
    typedef enum logic [1:0] {
        role_above,
        role_center,
        role_below
    } row_role_t;

    // prefill of the first image row
    typedef enum logic {
        pf_idle,
        pf_run
    } prefill_state_t;

endpackage

//--- rtl/dual_port_ram.sv
module dual_port_ram #(
    parameter int addr_w = 6,
    parameter int data_w = 32
) (
    input  logic              clk,
    input  logic              wr_en,
    input  logic [addr_w-1:0] wr_addr,
    input  logic [data_w-1:0] wr_data,
    input  logic              rd_en,
    input  logic [addr_w-1:0] rd_addr,
    output logic [data_w-1:0] rd_data
);

    // storage, one word per address
    logic [data_w-1:0] mem [2**addr_w];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read data held until the next enabled read
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/window_addr_gen.sv
module window_addr_gen
    import line_buf_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      sync_start,
    input  logic      scan_valid,
    input  dim_t      scan_row,
    input  dim_t      scan_col,
    input  chn_t      scan_chn,
    input  dim_t      img_width,
    input  dim_t      img_height,
    input  chn_t      img_channels,
    output logic      ifm_rd_en,
    output ifm_addr_t ifm_rd_addr,
    output logic      lookup_valid,
    output row_addr_t lookup_offset,
    output logic      lookup_first_row,
    output logic      lookup_last_row,
    output logic      lookup_row_end,
    output logic      prefill_wr,
    output row_addr_t prefill_offset,
    output logic      prefill_last
);

    prefill_state_t pf_state;
    row_addr_t      pf_cnt;
    // prefill read in flight, one stage ahead of prefill_wr
    logic           pf_rd_q;
    logic           pf_last_q;

    row_addr_t      row_stride;
    row_addr_t      elem_offset;
    ifm_addr_t      scan_addr;
    logic           pf_at_end;
    logic           is_first_row;
    logic           is_last_row;
    logic           is_row_end;

    // --------------------------------------------------
    // address arithmetic
    // --------------------------------------------------
    // words per image row
    assign row_stride  = row_addr_t'(img_width) * row_addr_t'(img_channels);
    assign elem_offset = row_addr_t'(scan_col) * row_addr_t'(img_channels)
                       + row_addr_t'(scan_chn);
    // fetch the element one row below the scanned one
    assign scan_addr   = (ifm_addr_t'(scan_row) + ifm_addr_t'(1)) * ifm_addr_t'(row_stride)
                       + ifm_addr_t'(elem_offset);

    assign pf_at_end    = (pf_cnt == row_stride - row_addr_t'(1));
    assign is_first_row = (scan_row == '0);
    assign is_last_row  = (scan_row == img_height - dim_t'(1));
    assign is_row_end   = (scan_col == img_width - dim_t'(1))
                       && (scan_chn == img_channels - chn_t'(1));

    // --------------------------------------------------
    // prefill FSM and tag registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pf_state         <= pf_idle;
            pf_cnt           <= '0;
            pf_rd_q          <= 1'b0;
            pf_last_q        <= 1'b0;
            ifm_rd_en        <= 1'b0;
            lookup_valid     <= 1'b0;
            lookup_first_row <= 1'b0;
            lookup_last_row  <= 1'b0;
            lookup_row_end   <= 1'b0;
            prefill_wr       <= 1'b0;
            prefill_last     <= 1'b0;
        end else begin
            // second prefill stage, lines up with the buffer read data
            prefill_wr       <= pf_rd_q & ~sync_start;
            prefill_last     <= pf_rd_q & pf_last_q & ~sync_start;
            // flags only matter when lookup_valid is set
            lookup_first_row <= is_first_row;
            lookup_last_row  <= is_last_row;
            lookup_row_end   <= is_row_end;
            if (sync_start) begin
                pf_state     <= pf_run;
                pf_cnt       <= '0;
                pf_rd_q      <= 1'b0;
                pf_last_q    <= 1'b0;
                ifm_rd_en    <= 1'b0;
                lookup_valid <= 1'b0;
            end else if (pf_state == pf_run) begin
                // one row-0 word per cycle from address 0
                pf_cnt       <= pf_cnt + row_addr_t'(1);
                pf_rd_q      <= 1'b1;
                pf_last_q    <= pf_at_end;
                ifm_rd_en    <= 1'b1;
                lookup_valid <= 1'b0;
                if (pf_at_end) begin
                    pf_state <= pf_idle;
                end
            end else begin
                pf_rd_q      <= 1'b0;
                pf_last_q    <= 1'b0;
                // nothing below the last row
                ifm_rd_en    <= scan_valid & ~is_last_row;
                lookup_valid <= scan_valid;
            end
        end
    end

    // addresses and offsets
    always_ff @(posedge clk) begin
        if (pf_state == pf_run) begin
            ifm_rd_addr <= ifm_addr_t'(pf_cnt);
        end else begin
            ifm_rd_addr <= scan_addr;
        end
        lookup_offset  <= elem_offset;
        // prefill reads stay below one row stride
        prefill_offset <= row_addr_t'(ifm_rd_addr);
    end

endmodule

//--- rtl/row_buffer_bank.sv
module row_buffer_bank
    import line_buf_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      sync_start,
    input  pixel_t    ifm_data,
    input  logic      lookup_valid,
    input  row_addr_t lookup_offset,
    input  logic      lookup_first_row,
    input  logic      lookup_last_row,
    input  logic      lookup_row_end,
    input  logic      prefill_wr,
    input  row_addr_t prefill_offset,
    input  logic      prefill_last,
    output logic      sync_done,
    output logic      window_valid_int,
    output logic      first_row_int,
    output logic      last_row_int,
    output pixel_t    row0_data,
    output pixel_t    row1_data,
    output pixel_t    row2_data,
    output row_role_t role0,
    output row_role_t role1,
    output row_role_t role2
);

    row_role_t role_q [3];
    pixel_t    row_data [3];
    logic      row_end_q;
    // offset of the element now at the output
    row_addr_t wr_off_q;
    logic      scan_wr;
    row_addr_t wr_addr;
    logic [2:0] wr_en;

    // below -> center -> above -> below
    function automatic row_role_t next_role(input row_role_t role);
        case (role)
            role_below:  return role_center;
            role_center: return role_above;
            default:     return role_below;
        endcase
    endfunction

    // --------------------------------------------------
    // write routing
    // --------------------------------------------------
    // below word arrives with the output, stored for the next row
    assign scan_wr = window_valid_int & ~last_row_int;
    // prefill and scan never overlap
    assign wr_addr = prefill_wr ? prefill_offset : wr_off_q;

    for (genvar i = 0; i < 3; i++) begin : g_row
        // prefill fills center, scans fill below
        assign wr_en[i] = (prefill_wr && role_q[i] == role_center)
                       || (scan_wr && role_q[i] == role_below);

        dual_port_ram #(
            .addr_w (row_aw),
            .data_w (pixel_w)
        ) row_ram_i (
            .clk     (clk),
            .wr_en   (wr_en[i]),
            .wr_addr (wr_addr),
            .wr_data (ifm_data),
            .rd_en   (lookup_valid),
            .rd_addr (lookup_offset),
            .rd_data (row_data[i])
        );
    end

    // --------------------------------------------------
    // roles, output tags, sync completion
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            role_q[0]        <= role_center;
            role_q[1]        <= role_below;
            role_q[2]        <= role_above;
            sync_done        <= 1'b0;
            window_valid_int <= 1'b0;
            first_row_int    <= 1'b0;
            last_row_int     <= 1'b0;
            row_end_q        <= 1'b0;
        end else if (sync_start) begin
            // new pass, row 0 goes to row0
            role_q[0]        <= role_center;
            role_q[1]        <= role_below;
            role_q[2]        <= role_above;
            sync_done        <= 1'b0;
            window_valid_int <= 1'b0;
            first_row_int    <= 1'b0;
            last_row_int     <= 1'b0;
            row_end_q        <= 1'b0;
        end else begin
            window_valid_int <= lookup_valid;
            first_row_int    <= lookup_first_row;
            last_row_int     <= lookup_last_row;
            row_end_q        <= lookup_valid & lookup_row_end;
            // high for the cycle after the last row-0 write
            sync_done        <= prefill_wr & prefill_last;
            // rotate after the last element of a row has left
            if (window_valid_int && row_end_q) begin
                for (int i = 0; i < 3; i++) begin
                    role_q[i] <= next_role(role_q[i]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_off_q <= lookup_offset;
    end

    assign row0_data = row_data[0];
    assign row1_data = row_data[1];
    assign row2_data = row_data[2];
    assign role0     = role_q[0];
    assign role1     = role_q[1];
    assign role2     = role_q[2];

endmodule

//--- rtl/window_select.sv
module window_select
    import line_buf_pkg::*;
(
    input  logic      window_valid_int,
    input  logic      first_row_int,
    input  logic      last_row_int,
    input  pixel_t    row0_data,
    input  pixel_t    row1_data,
    input  pixel_t    row2_data,
    input  row_role_t role0,
    input  row_role_t role1,
    input  row_role_t role2,
    input  pixel_t    ifm_data,
    output logic      window_valid,
    output pixel_t    window_above,
    output pixel_t    window_center,
    output pixel_t    window_below
);

    pixel_t above_sel;
    pixel_t center_sel;

    // exactly one RAM holds each role
    always_comb begin
        above_sel  = '0;
        center_sel = '0;
        if (role0 == role_above) begin
            above_sel = row0_data;
        end else if (role1 == role_above) begin
            above_sel = row1_data;
        end else if (role2 == role_above) begin
            above_sel = row2_data;
        end
        if (role0 == role_center) begin
            center_sel = row0_data;
        end else if (role1 == role_center) begin
            center_sel = row1_data;
        end else if (role2 == role_center) begin
            center_sel = row2_data;
        end
    end

    assign window_valid  = window_valid_int;
    // zero padding at top and bottom
    assign window_above  = (window_valid_int && !first_row_int) ? above_sel : '0;
    assign window_center = window_valid_int ? center_sel : '0;
    // below word comes straight from the feature buffer
    assign window_below  = (window_valid_int && !last_row_int) ? ifm_data : '0;

endmodule

//--- rtl/line_window_top.sv
module line_window_top
    import line_buf_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      load_valid,
    input  ifm_addr_t load_addr,
    input  pixel_t    load_data,
    input  dim_t      img_width,
    input  dim_t      img_height,
    input  chn_t      img_channels,
    input  logic      sync_start,
    output logic      sync_done,
    input  logic      scan_valid,
    input  dim_t      scan_row,
    input  dim_t      scan_col,
    input  chn_t      scan_chn,
    output logic      window_valid,
    output pixel_t    window_above,
    output pixel_t    window_center,
    output pixel_t    window_below
);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------
    logic      ifm_rd_en;
    ifm_addr_t ifm_rd_addr;
    pixel_t    ifm_data;
    logic      lookup_valid;
    row_addr_t lookup_offset;
    logic      lookup_first_row;
    logic      lookup_last_row;
    logic      lookup_row_end;
    logic      prefill_wr;
    row_addr_t prefill_offset;
    logic      prefill_last;
    logic      window_valid_int;
    logic      first_row_int;
    logic      last_row_int;
    pixel_t    row0_data;
    pixel_t    row1_data;
    pixel_t    row2_data;
    row_role_t role0;
    row_role_t role1;
    row_role_t role2;

    // whole IFM, loaded from outside, read by the address generator
    dual_port_ram #(
        .addr_w (ifm_aw),
        .data_w (pixel_w)
    ) ifm_buffer_i (
        .clk     (clk),
        .wr_en   (load_valid),
        .wr_addr (load_addr),
        .wr_data (load_data),
        .rd_en   (ifm_rd_en),
        .rd_addr (ifm_rd_addr),
        .rd_data (ifm_data)
    );

    // decode
    window_addr_gen window_addr_gen_i (
        .clk              (clk),
        .rstn             (rstn),
        .sync_start       (sync_start),
        .scan_valid       (scan_valid),
        .scan_row         (scan_row),
        .scan_col         (scan_col),
        .scan_chn         (scan_chn),
        .img_width        (img_width),
        .img_height       (img_height),
        .img_channels     (img_channels),
        .ifm_rd_en        (ifm_rd_en),
        .ifm_rd_addr      (ifm_rd_addr),
        .lookup_valid     (lookup_valid),
        .lookup_offset    (lookup_offset),
        .lookup_first_row (lookup_first_row),
        .lookup_last_row  (lookup_last_row),
        .lookup_row_end   (lookup_row_end),
        .prefill_wr       (prefill_wr),
        .prefill_offset   (prefill_offset),
        .prefill_last     (prefill_last)
    );

    // execute
    row_buffer_bank row_buffer_bank_i (
        .clk              (clk),
        .rstn             (rstn),
        .sync_start       (sync_start),
        .ifm_data         (ifm_data),
        .lookup_valid     (lookup_valid),
        .lookup_offset    (lookup_offset),
        .lookup_first_row (lookup_first_row),
        .lookup_last_row  (lookup_last_row),
        .lookup_row_end   (lookup_row_end),
        .prefill_wr       (prefill_wr),
        .prefill_offset   (prefill_offset),
        .prefill_last     (prefill_last),
        .sync_done        (sync_done),
        .window_valid_int (window_valid_int),
        .first_row_int    (first_row_int),
        .last_row_int     (last_row_int),
        .row0_data        (row0_data),
        .row1_data        (row1_data),
        .row2_data        (row2_data),
        .role0            (role0),
        .role1            (role1),
        .role2            (role2)
    );

    // result
    window_select window_select_i (
        .window_valid_int (window_valid_int),
        .first_row_int    (first_row_int),
        .last_row_int     (last_row_int),
        .row0_data        (row0_data),
        .row1_data        (row1_data),
        .row2_data        (row2_data),
        .role0            (role0),
        .role1            (role1),
        .role2            (role2),
        .ifm_data         (ifm_data),
        .window_valid     (window_valid),
        .window_above     (window_above),
        .window_center    (window_center),
        .window_below     (window_below)
    );

endmodule

//--- tests/line_window_assert.sv
module line_window_assert (
    input logic clk,
    input logic rstn,
    input logic strobe_in,
    input logic strobe_out,
    input logic busy,
    input logic pulse
);

    // --------------------------------------------------
    // strobe and pulse rules, one stage at a time
    // --------------------------------------------------
    // no new strobe while the first row is moving in
    strobe_not_busy: assert property (
        @(posedge clk) disable iff (!rstn) !(strobe_in && busy)
    ) else $error("strobe arrived while the prefill was running");

    // done-type pulses last one cycle
    pulse_one_cycle: assert property (
        @(posedge clk) disable iff (!rstn) pulse |=> !pulse
    ) else $error("pulse held high for more than one cycle");

    // each stage adds exactly one cycle
    strobe_follows: assert property (
        @(posedge clk) disable iff (!rstn) strobe_out == $past(strobe_in)
    ) else $error("stage output strobe does not follow its input by one cycle");

endmodule

// scan strobe to lookup tags, no scan during prefill
bind window_addr_gen line_window_assert addr_gen_assert_i (
    .clk        (clk),
    .rstn       (rstn),
    .strobe_in  (scan_valid),
    .strobe_out (lookup_valid),
    .busy       (pf_state == pf_run),
    .pulse      (prefill_last)
);

// lookup tags to window_valid, sync_done width
bind row_buffer_bank line_window_assert bank_assert_i (
    .clk        (clk),
    .rstn       (rstn),
    .strobe_in  (lookup_valid),
    .strobe_out (window_valid_int),
    .busy       (prefill_wr),
    .pulse      (sync_done)
);

//--- tests/tb_checker.sv
module tb_checker
    import line_buf_pkg::*;
(
    input  logic   clk,
    input  logic   rstn,
    input  logic   sync_start,
    input  logic   sync_done,
    input  dim_t   img_width,
    input  chn_t   img_channels,
    input  logic   scan_valid,
    input  pixel_t exp_above,
    input  pixel_t exp_center,
    input  pixel_t exp_below,
    input  logic   window_valid,
    input  pixel_t window_above,
    input  pixel_t window_center,
    input  pixel_t window_below,
    output int     error_count,
    output int     check_count,
    output int     pending
);

    // expected triples, oldest scan first
    pixel_t above_q [$];
    pixel_t center_q [$];
    pixel_t below_q [$];
    // cycle at which each window is due
    int     due_q [$];
    int     cycle;
    int     sync_cycle;
    int     stride;
    logic   sync_wait;

    task automatic compare_word(input string name, input pixel_t expected, input pixel_t actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic drop_oldest();
        void'(above_q.pop_front());
        void'(center_q.pop_front());
        void'(below_q.pop_front());
        void'(due_q.pop_front());
    endtask

    // --------------------------------------------------
    // sampled on the edge, before the DUT registers move
    // --------------------------------------------------
    always @(posedge clk) begin
        if (!rstn) begin
            cycle       = 0;
            sync_cycle  = 0;
            stride      = 0;
            sync_wait   = 1'b0;
            error_count = 0;
            check_count = 0;
            above_q.delete();
            center_q.delete();
            below_q.delete();
            due_q.delete();
        end else begin
            cycle = cycle + 1;
            if (window_valid) begin
                if (due_q.size() == 0) begin
                    error_count++;
                    $display("window_valid at %0t came with no scan pending", $time);
                end else begin
                    // scan to window is fixed at 2 cycles
                    if (due_q[0] != cycle) begin
                        error_count++;
                        $display("error at %0t: window_valid delay expected 2, got %0d",
                                 $time, cycle - due_q[0] + 2);
                    end
                    compare_word("window_above", above_q[0], window_above);
                    compare_word("window_center", center_q[0], window_center);
                    compare_word("window_below", below_q[0], window_below);
                    drop_oldest();
                end
            end else begin
                // idle outputs stay at zero
                compare_word("window_above", '0, window_above);
                compare_word("window_center", '0, window_center);
                compare_word("window_below", '0, window_below);
            end
            // window never showed up
            if (due_q.size() > 0 && due_q[0] < cycle) begin
                error_count++;
                $display("window_valid missing at %0t for a scan due at cycle %0d",
                         $time, due_q[0]);
                drop_oldest();
            end
            if (scan_valid) begin
                above_q.push_back(exp_above);
                center_q.push_back(exp_center);
                below_q.push_back(exp_below);
                due_q.push_back(cycle + 2);
            end
            // sync_done rises stride + 2 edges after the edge taking sync_start,
            // so it is sampled high one edge later
            if (sync_start) begin
                sync_wait  = 1'b1;
                sync_cycle = cycle;
                stride     = int'(img_width) * int'(img_channels);
            end
            if (sync_done) begin
                check_count++;
                if (!sync_wait) begin
                    error_count++;
                    $display("sync_done pulsed at %0t with no sync_start pending", $time);
                end else if (cycle - sync_cycle != stride + 3) begin
                    error_count++;
                    $display("error at %0t: sync_done delay expected %0d, got %0d",
                             $time, stride + 2, cycle - sync_cycle - 1);
                end
                sync_wait = 1'b0;
            end
            pending = due_q.size();
        end
    end

endmodule

//--- tests/tb_top.sv
module tb_top
    import line_buf_pkg::*;
();

    localparam int max_cases     = 8;
    localparam int sync_timeout  = 200;
    localparam int drain_timeout = 20;

    logic      clk;
    logic      rstn;
    logic      load_valid;
    ifm_addr_t load_addr;
    pixel_t    load_data;
    dim_t      img_width;
    dim_t      img_height;
    chn_t      img_channels;
    logic      sync_start;
    logic      sync_done;
    logic      scan_valid;
    dim_t      scan_row;
    dim_t      scan_col;
    chn_t      scan_chn;
    logic      window_valid;
    pixel_t    window_above;
    pixel_t    window_center;
    pixel_t    window_below;

    // expected triple, presented with each scan strobe
    pixel_t    exp_above;
    pixel_t    exp_center;
    pixel_t    exp_below;
    int        error_count;
    int        check_count;
    int        pending;

    // width, height, channels per case
    logic [7:0]  case_mem [0:3*max_cases-1];
    // copy of the feature buffer contents
    pixel_t      model [1024];
    logic [31:0] rng_state;
    int          case_num;
    logic        timed_out;

    line_window_top dut_i (
        .clk           (clk),
        .rstn          (rstn),
        .load_valid    (load_valid),
        .load_addr     (load_addr),
        .load_data     (load_data),
        .img_width     (img_width),
        .img_height    (img_height),
        .img_channels  (img_channels),
        .sync_start    (sync_start),
        .sync_done     (sync_done),
        .scan_valid    (scan_valid),
        .scan_row      (scan_row),
        .scan_col      (scan_col),
        .scan_chn      (scan_chn),
        .window_valid  (window_valid),
        .window_above  (window_above),
        .window_center (window_center),
        .window_below  (window_below)
    );

    tb_checker chk_i (
        .clk           (clk),
        .rstn          (rstn),
        .sync_start    (sync_start),
        .sync_done     (sync_done),
        .img_width     (img_width),
        .img_channels  (img_channels),
        .scan_valid    (scan_valid),
        .exp_above     (exp_above),
        .exp_center    (exp_center),
        .exp_below     (exp_below),
        .window_valid  (window_valid),
        .window_above  (window_above),
        .window_center (window_center),
        .window_below  (window_below),
        .error_count   (error_count),
        .check_count   (check_count),
        .pending       (pending)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // 32-bit xorshift
    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // zero outside the image, padding rule
    function automatic pixel_t model_word(input int row, input int col, input int chn,
                                          input int w, input int h, input int c);
        if (row < 0 || row >= h) begin
            return '0;
        end
        return model[(row * w + col) * c + chn];
    endfunction

    // next edge, then the input change point
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    // --------------------------------------------------
    // stimulus tasks
    // --------------------------------------------------
    task automatic load_image(input int words);
        for (int a = 0; a < words; a++) begin
            rng_state  = next_random(rng_state);
            load_valid = 1'b1;
            load_addr  = ifm_addr_t'(a);
            load_data  = rng_state;
            model[a]   = rng_state;
            step();
        end
        load_valid = 1'b0;
    endtask

    task automatic run_sync(input int timeout, output logic ok);
        int n;
        n  = 0;
        ok = 1'b0;
        sync_start = 1'b1;
        step();
        sync_start = 1'b0;
        while (!ok && n < timeout) begin
            step();
            ok = sync_done;
            n++;
        end
    endtask

    // raster order, channel fastest
    task automatic scan_image(input int w, input int h, input int c, input logic gaps);
        int gap;
        for (int r = 0; r < h; r++) begin
            for (int x = 0; x < w; x++) begin
                for (int ch = 0; ch < c; ch++) begin
                    scan_valid = 1'b1;
                    scan_row   = dim_t'(r);
                    scan_col   = dim_t'(x);
                    scan_chn   = chn_t'(ch);
                    exp_above  = model_word(r - 1, x, ch, w, h, c);
                    exp_center = model_word(r, x, ch, w, h, c);
                    exp_below  = model_word(r + 1, x, ch, w, h, c);
                    step();
                    scan_valid = 1'b0;
                    if (gaps) begin
                        rng_state = next_random(rng_state);
                        gap = int'(rng_state[1:0]);
                        repeat (gap) step();
                    end
                end
            end
        end
    endtask

    // until every pending window has been checked
    task automatic wait_drain(input int timeout, output logic ok);
        int n;
        n  = 0;
        ok = (pending == 0);
        while (!ok && n < timeout) begin
            step();
            ok = (pending == 0);
            n++;
        end
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        logic ok;
        int   w;
        int   h;
        int   c;
        rstn         = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        img_width    = '0;
        img_height   = '0;
        img_channels = '0;
        sync_start   = 1'b0;
        scan_valid   = 1'b0;
        scan_row     = '0;
        scan_col     = '0;
        scan_chn     = '0;
        exp_above    = '0;
        exp_center   = '0;
        exp_below    = '0;
        rng_state    = 32'd14;
        timed_out    = 1'b0;
        for (int i = 0; i < 3 * max_cases; i++) begin
            case_mem[i] = '0;
        end
        $readmemh("tests/stim_cases.txt", case_mem);
        repeat (5) @(posedge clk);
        #2;
        rstn = 1'b1;
        step();
        case_num = 0;
        // a zero width ends the case list
        while (!timed_out && case_num < max_cases && case_mem[3 * case_num] != 8'd0) begin
            w = int'(case_mem[3 * case_num]);
            h = int'(case_mem[3 * case_num + 1]);
            c = int'(case_mem[3 * case_num + 2]);
            img_width    = dim_t'(w);
            img_height   = dim_t'(h);
            img_channels = chn_t'(c);
            load_image(w * h * c);
            run_sync(sync_timeout, ok);
            if (!ok) begin
                $display("timeout: sync_done never came in case %0d", case_num);
                timed_out = 1'b1;
            end else begin
                // odd cases get random gaps between scans
                scan_image(w, h, c, case_num % 2 == 1);
                wait_drain(drain_timeout, ok);
                if (!ok) begin
                    $display("timeout: windows still pending after case %0d", case_num);
                    timed_out = 1'b1;
                end
            end
            case_num++;
        end
        $display("cases %0d, checks %0d, errors %0d", case_num, check_count, error_count);
        if (error_count == 0 && !timed_out) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tests/stim_cases.txt
// one test case per line, hex: width height channels
// width * channels stays between 2 and 64, all words fit in 1024
4 3 2
5 4 1
3 5 3
8 2 4
6 1 2
7 9 7
f 8 4

//--- tb.f
rtl/line_buf_pkg.sv
rtl/dual_port_ram.sv
rtl/window_addr_gen.sv
rtl/row_buffer_bank.sv
rtl/window_select.sv
rtl/line_window_top.sv
tests/line_window_assert.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the line window testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module tb_top -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$log"; then
    exit 1
fi
exit 0
